// ==== logic/gw_pkg.sv ====
package gw_pkg;

  ////////////////////////////////////////
  // Sizes

  localparam int default_num_columns = 8;
  localparam int default_decay_max   = 31;
  localparam int default_decay_show  = 16;
  localparam int default_num_digits  = 9;

  ////////////////////////////////////////
  // Types

  typedef enum logic {
    sm510 = 1'b0,
    sm5a  = 1'b1
  } cpu_kind_t;

  typedef struct packed {
    logic dpad_up;
    logic dpad_down;
    logic dpad_left;
    logic dpad_right;
    logic button_a;
    logic button_b;
    logic button_x;
    logic button_y;
    logic trig_l;
    logic trig_r;
    logic start;
    logic select;
  } buttons_t;

  // Index 0..7 are key columns S0..S7
  typedef struct packed {
    logic [3:0]  index;
    logic [31:0] data;
  } cfg_wr_t;

  typedef struct packed {
    logic [15:0] a;
    logic [15:0] b;
    logic        bs;
  } sm510_seg_t;

  typedef logic [default_num_digits-1:0][3:0] w_digits_t;

  typedef struct packed {
    logic [3:0] line_select;
    logic [3:0] column;
    logic [1:0] row;
    logic       has_segment;
  } seg_query_t;

  ////////////////////////////////////////
  // Control codes

  localparam logic [6:0] ctl_dpad_up      = 7'd0;
  localparam logic [6:0] ctl_dpad_down    = 7'd1;
  localparam logic [6:0] ctl_dpad_left    = 7'd2;
  localparam logic [6:0] ctl_dpad_right   = 7'd3;
  localparam logic [6:0] ctl_button_b     = 7'd4;
  localparam logic [6:0] ctl_button_a     = 7'd5;
  localparam logic [6:0] ctl_button_y     = 7'd6;
  localparam logic [6:0] ctl_button_x     = 7'd7;
  localparam logic [6:0] ctl_trig_l       = 7'd12;
  localparam logic [6:0] ctl_select       = 7'd13;
  localparam logic [6:0] ctl_start        = 7'd14;
  localparam logic [6:0] ctl_trig_r       = 7'd16;
  localparam logic [6:0] ctl_lstick_up    = 7'd17;
  localparam logic [6:0] ctl_lstick_down  = 7'd18;
  localparam logic [6:0] ctl_lstick_left  = 7'd19;
  localparam logic [6:0] ctl_lstick_right = 7'd20;
  localparam logic [6:0] ctl_rstick_up    = 7'd21;
  localparam logic [6:0] ctl_rstick_down  = 7'd22;
  localparam logic [6:0] ctl_rstick_left  = 7'd23;
  localparam logic [6:0] ctl_rstick_right = 7'd24;
  localparam logic [6:0] ctl_unused       = 7'd127;

  localparam logic [3:0]  cfg_idx_beta    = 4'd8;
  localparam logic [3:0]  cfg_idx_ba      = 4'd9;
  localparam logic [31:0] cfg_unused_word = {4{1'b0, ctl_unused}};

  // Bit 7 of the code inverts the control
  function automatic logic map_control(logic [7:0] code, buttons_t btn);
    logic hit;
    case (code[6:0])
      ctl_dpad_up, ctl_lstick_up:       hit = btn.dpad_up;
      ctl_dpad_down, ctl_lstick_down:   hit = btn.dpad_down;
      ctl_dpad_left, ctl_lstick_left:   hit = btn.dpad_left;
      ctl_dpad_right, ctl_lstick_right: hit = btn.dpad_right;
      ctl_button_b, ctl_rstick_down:    hit = btn.button_b;
      ctl_button_a, ctl_rstick_right:   hit = btn.button_a;
      ctl_button_y, ctl_rstick_left:    hit = btn.button_y;
      ctl_button_x, ctl_rstick_up:      hit = btn.button_x;
      ctl_trig_l:                       hit = btn.trig_l;
      ctl_select:                       hit = btn.select;
      ctl_start:                        hit = btn.start;
      ctl_trig_r:                       hit = btn.trig_r;
      ctl_unused:                       hit = 1'b0;
      default:                          hit = 1'b0;
    endcase
    return code[7] ? ~hit : hit;
  endfunction

endpackage

// ==== logic/gw_input_decode.sv ====
`timescale 1ns/100ps

module gw_input_decode
  import gw_pkg::*;
#(
  parameter int num_columns = 8
) (
  input  logic       clk_sys_131_072,
  input  logic       reset,
  input  logic       cfg_valid,
  output logic       cfg_ready,
  input  cfg_wr_t    cfg,
  input  buttons_t   buttons,
  input  cpu_kind_t  cpu_kind,
  input  logic [7:0] strobe_s,
  input  logic [3:0] strobe_r,
  output logic [3:0] input_k,
  output logic       input_beta,
  output logic       input_ba
);

  localparam int sel_w = (num_columns > 1) ? $clog2(num_columns) : 1;

  logic [31:0] col_cfg [num_columns];
  logic [7:0]  beta_cfg;
  logic [7:0]  ba_cfg;

  // Comb
  logic [31:0] active_cfg;

  ////////////////////////////////////////
  // Config registers

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      for (int i = 0; i < num_columns; i++) begin
        col_cfg[i] <= cfg_unused_word;
      end
      beta_cfg  <= cfg_unused_word[7:0];
      ba_cfg    <= cfg_unused_word[7:0];
      cfg_ready <= 1'b0;
    end else begin
      cfg_ready <= 1'b1;
      if (cfg_valid && cfg_ready) begin
        if (cfg.index == cfg_idx_beta) begin
          beta_cfg <= cfg.data[7:0];
        end else if (cfg.index == cfg_idx_ba) begin
          ba_cfg <= cfg.data[7:0];
        end else if (int'(cfg.index) < num_columns) begin
          col_cfg[cfg.index[sel_w-1:0]] <= cfg.data;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Active column

  // Lowest strobe wins, S0 when idle
  always_comb begin
    active_cfg = col_cfg[0];
    if (cpu_kind == sm5a) begin
      // R1..R3 pick S0..S2
      for (int i = 3; i >= 1; i--) begin
        if (strobe_r[i]) begin
          active_cfg = col_cfg[i-1];
        end
      end
    end else begin
      for (int i = num_columns - 1; i >= 0; i--) begin
        if (strobe_s[i]) begin
          active_cfg = col_cfg[i];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Registered CPU inputs

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      input_k    <= 4'h0;
      input_beta <= 1'b0;
      input_ba   <= 1'b0;
    end else begin
      // Byte n drives K bit n
      input_k <= {
        map_control(active_cfg[31:24], buttons),
        map_control(active_cfg[23:16], buttons),
        map_control(active_cfg[15:8], buttons),
        map_control(active_cfg[7:0], buttons)
      };
      input_beta <= map_control(beta_cfg, buttons);
      input_ba   <= map_control(ba_cfg, buttons);
    end
  end

  // Only S0..S7, beta and BA exist
  a_cfg_index_range: assert property (
    @(posedge clk_sys_131_072) disable iff (reset)
    cfg_valid && cfg_ready |-> cfg.index <= cfg_idx_ba
  ) else $error("config write to index %0d", cfg.index);

endmodule

// ==== logic/gw_segment_capture.sv ====
`timescale 1ns/100ps

module gw_segment_capture
  import gw_pkg::*;
#(
  parameter int num_digits = 9,
  parameter int decay_max  = 31,
  parameter int decay_show = 16
) (
  input  logic             clk_sys_131_072,
  input  logic             reset,
  input  logic [1:0]       lcd_h_index,
  input  sm510_seg_t       seg_live,
  input  w_digits_t        w_prime_live,
  input  w_digits_t        w_main_live,
  input  logic             tick_1khz,
  input  logic             vblank,
  output logic [3:0][15:0] seg_cache_a,
  output logic [3:0][15:0] seg_cache_b,
  output logic [3:0]       seg_cache_bs,
  output w_digits_t        w_prime_shown,
  output w_digits_t        w_main_shown
);

  localparam int cnt_w = $clog2(decay_max + 1);

  // Segment sets as last driven for each H
  sm510_seg_t seg_store [4];

  // Index 0 is W, index 1 is W'
  w_digits_t  w_store [2];
  w_digits_t  w_shown [2];
  logic [cnt_w-1:0] decay [2][num_digits][4];

  logic vblank_prev;
  logic tick_prev;

  // Comb
  logic vblank_rise;
  logic tick_rise;
  logic over_max;

  assign vblank_rise = vblank && !vblank_prev;
  assign tick_rise   = tick_1khz && !tick_prev;

  ////////////////////////////////////////
  // Capture and SM510 cache

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      vblank_prev  <= 1'b0;
      tick_prev    <= 1'b0;
      seg_cache_a  <= '0;
      seg_cache_b  <= '0;
      seg_cache_bs <= '0;
      for (int h = 0; h < 4; h++) begin
        seg_store[h] <= '0;
      end
      w_store[0] <= '0;
      w_store[1] <= '0;
    end else begin
      vblank_prev <= vblank;
      tick_prev   <= tick_1khz;

      seg_store[lcd_h_index] <= seg_live;

      // Odd H carries W', even H carries W
      if (lcd_h_index[0]) begin
        w_store[1] <= w_prime_live;
      end else begin
        w_store[0] <= w_main_live;
      end

      if (vblank_rise) begin
        for (int h = 0; h < 4; h++) begin
          seg_cache_a[h]  <= seg_store[h].a;
          seg_cache_b[h]  <= seg_store[h].b;
          seg_cache_bs[h] <= seg_store[h].bs;
        end
      end
    end
  end

  ////////////////////////////////////////
  // W/W' persistence

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      w_shown[0] <= '0;
      w_shown[1] <= '0;
      for (int k = 0; k < 2; k++) begin
        for (int i = 0; i < num_digits; i++) begin
          for (int j = 0; j < 4; j++) begin
            decay[k][i][j] <= '0;
          end
        end
      end
    end else if (tick_rise) begin
      for (int k = 0; k < 2; k++) begin
        for (int i = 0; i < num_digits; i++) begin
          for (int j = 0; j < 4; j++) begin
            // Lit segments charge up, dark ones bleed off
            if (w_store[k][i][j] && decay[k][i][j] < decay_max) begin
              decay[k][i][j] <= decay[k][i][j] + 1'b1;
            end else if (!w_store[k][i][j] && decay[k][i][j] > 0) begin
              decay[k][i][j] <= decay[k][i][j] - 1'b1;
            end
            // Uses the count from before this tick
            w_shown[k][i][j] <= decay[k][i][j] > decay_show;
          end
        end
      end
    end
  end

  assign w_main_shown  = w_shown[0];
  assign w_prime_shown = w_shown[1];

  always_comb begin
    over_max = 1'b0;
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < num_digits; i++) begin
        for (int j = 0; j < 4; j++) begin
          over_max |= decay[k][i][j] > decay_max;
        end
      end
    end
  end

  a_decay_bounded: assert property (
    @(posedge clk_sys_131_072) disable iff (reset)
    !over_max
  ) else $error("decay counter above %0d", decay_max);

endmodule

// ==== logic/gw_segment_lookup.sv ====
`timescale 1ns/100ps

module gw_segment_lookup
  import gw_pkg::*;
#(
  parameter int num_digits = 9
) (
  input  logic             clk_sys_131_072,
  input  logic             reset,
  input  cpu_kind_t        cpu_kind,
  input  logic             query_valid,
  output logic             query_ready,
  input  seg_query_t       query,
  input  logic [3:0][15:0] seg_cache_a,
  input  logic [3:0][15:0] seg_cache_b,
  input  logic [3:0]       seg_cache_bs,
  input  w_digits_t        w_prime_shown,
  input  w_digits_t        w_main_shown,
  output logic             resp_valid,
  input  logic             resp_ready,
  output logic             display_segment
);

  // Comb
  logic hit;

  always_comb begin
    hit = 1'b0;
    if (query.has_segment) begin
      if (cpu_kind == sm5a) begin
        // Line select is the digit, column the bit within it
        if (int'(query.line_select) < num_digits && query.column[3:2] == 2'b00) begin
          if (query.row == 2'd1) begin
            hit = w_prime_shown[query.line_select][query.column[1:0]];
          end else begin
            hit = w_main_shown[query.line_select][query.column[1:0]];
          end
        end
      end else begin
        case (query.line_select)
          4'd0:    hit = seg_cache_a[query.row][query.column];
          4'd1:    hit = seg_cache_b[query.row][query.column];
          4'd2:    hit = seg_cache_bs[query.row];
          default: hit = 1'b0;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Response register

  // Accept while empty or draining
  assign query_ready = !resp_valid || resp_ready;

  always_ff @(posedge clk_sys_131_072) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else if (query_valid && query_ready) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys_131_072) begin
    if (query_valid && query_ready) begin
      display_segment <= hit;
    end
  end

  a_resp_held: assert property (
    @(posedge clk_sys_131_072) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(display_segment)
  ) else $error("response changed under back-pressure");

endmodule

// ==== logic/gw_lcd_front.sv ====
`timescale 1ns/100ps

module gw_lcd_front
  import gw_pkg::*;
#(
  parameter int num_columns = default_num_columns,
  parameter int decay_max   = default_decay_max,
  parameter int decay_show  = default_decay_show,
  parameter int num_digits  = default_num_digits
) (
  input  logic       clk_sys_131_072,
  input  logic       reset,
  // Configuration port
  input  logic       cfg_valid,
  output logic       cfg_ready,
  input  cfg_wr_t    cfg,
  // From the CPU side
  input  buttons_t   buttons,
  input  cpu_kind_t  cpu_kind,
  input  logic [7:0] strobe_s,
  input  logic [3:0] strobe_r,
  output logic [3:0] input_k,
  output logic       input_beta,
  output logic       input_ba,
  input  logic [1:0] lcd_h_index,
  input  sm510_seg_t seg_live,
  input  w_digits_t  w_prime_live,
  input  w_digits_t  w_main_live,
  input  logic       tick_1khz,
  input  logic       vblank,
  // Mask queries
  input  logic       query_valid,
  output logic       query_ready,
  input  seg_query_t query,
  output logic       resp_valid,
  input  logic       resp_ready,
  output logic       display_segment
);

  logic [3:0][15:0] seg_cache_a;
  logic [3:0][15:0] seg_cache_b;
  logic [3:0]       seg_cache_bs;
  w_digits_t        w_prime_shown;
  w_digits_t        w_main_shown;

  gw_input_decode #(
    .num_columns(num_columns)
  ) i_decode (
    .clk_sys_131_072(clk_sys_131_072),
    .reset          (reset),
    .cfg_valid      (cfg_valid),
    .cfg_ready      (cfg_ready),
    .cfg            (cfg),
    .buttons        (buttons),
    .cpu_kind       (cpu_kind),
    .strobe_s       (strobe_s),
    .strobe_r       (strobe_r),
    .input_k        (input_k),
    .input_beta     (input_beta),
    .input_ba       (input_ba)
  );

  gw_segment_capture #(
    .num_digits(num_digits),
    .decay_max (decay_max),
    .decay_show(decay_show)
  ) i_capture (
    .clk_sys_131_072(clk_sys_131_072),
    .reset          (reset),
    .lcd_h_index    (lcd_h_index),
    .seg_live       (seg_live),
    .w_prime_live   (w_prime_live),
    .w_main_live    (w_main_live),
    .tick_1khz      (tick_1khz),
    .vblank         (vblank),
    .seg_cache_a    (seg_cache_a),
    .seg_cache_b    (seg_cache_b),
    .seg_cache_bs   (seg_cache_bs),
    .w_prime_shown  (w_prime_shown),
    .w_main_shown   (w_main_shown)
  );

  gw_segment_lookup #(
    .num_digits(num_digits)
  ) i_lookup (
    .clk_sys_131_072(clk_sys_131_072),
    .reset          (reset),
    .cpu_kind       (cpu_kind),
    .query_valid    (query_valid),
    .query_ready    (query_ready),
    .query          (query),
    .seg_cache_a    (seg_cache_a),
    .seg_cache_b    (seg_cache_b),
    .seg_cache_bs   (seg_cache_bs),
    .w_prime_shown  (w_prime_shown),
    .w_main_shown   (w_main_shown),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .display_segment(display_segment)
  );

endmodule

// ==== tb/gw_checker.sv ====
`timescale 1ns/100ps

module gw_checker
  import gw_pkg::*;
(
  input logic       clk_sys_131_072,
  input logic       reset,
  input logic       cfg_valid,
  input logic       cfg_ready,
  input cfg_wr_t    cfg,
  input buttons_t   buttons,
  input cpu_kind_t  cpu_kind,
  input logic [7:0] strobe_s,
  input logic [3:0] strobe_r,
  input logic [3:0] input_k,
  input logic       input_beta,
  input logic       input_ba,
  input logic       query_ready,
  input logic       resp_valid,
  input logic       resp_ready,
  input logic       display_segment
);

  int error_count = 0;
  int check_count = 0;
  int test_errors = 0;

  // Reference copy of the config registers
  logic [31:0] col_model [8];
  logic [7:0]  beta_model;
  logic [7:0]  ba_model;

  logic [3:0] exp_k;
  logic       exp_beta;
  logic       exp_ba;
  logic       exp_ready;
  bit         exp_live;
  bit         exp_resp [$];
  bit         held;
  logic       held_bit;
  logic [31:0] word;

  task automatic flag(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic expect_bit(input bit value);
    exp_resp.push_back(value);
  endtask

  function automatic int pending();
    return exp_resp.size();
  endfunction

  task automatic report(input string name);
    $display("test %-12s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
    test_errors = 0;
  endtask

  task automatic summary();
    $display("checks %0d, errors %0d", check_count, error_count);
  endtask

  // Control code to player control, bit 7 inverts
  function automatic logic control_value(input logic [7:0] code, input buttons_t btn);
    logic v;
    case (code[6:0])
      0, 17:   v = btn.dpad_up;
      1, 18:   v = btn.dpad_down;
      2, 19:   v = btn.dpad_left;
      3, 20:   v = btn.dpad_right;
      4, 22:   v = btn.button_b;
      5, 24:   v = btn.button_a;
      6, 23:   v = btn.button_y;
      7, 21:   v = btn.button_x;
      12:      v = btn.trig_l;
      13:      v = btn.select;
      14:      v = btn.start;
      16:      v = btn.trig_r;
      default: v = 1'b0;
    endcase
    return v ^ code[7];
  endfunction

  function automatic logic [31:0] active_column(input cpu_kind_t kind, input logic [7:0] s,
                                                input logic [3:0] r);
    logic [31:0] w;
    w = col_model[0];
    if (kind == sm5a) begin
      if (r[1]) w = col_model[0];
      else if (r[2]) w = col_model[1];
      else if (r[3]) w = col_model[2];
    end else begin
      for (int i = 7; i >= 0; i--) begin
        if (s[i]) w = col_model[i];
      end
    end
    return w;
  endfunction

  always @(posedge clk_sys_131_072) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) col_model[i] = 32'h7F7F7F7F;
      beta_model = 8'h7F;
      ba_model   = 8'h7F;
      // Registered outputs read 0 and cfg_ready low just after reset
      exp_k      = '0;
      exp_beta   = 1'b0;
      exp_ba     = 1'b0;
      exp_ready  = 1'b0;
      exp_live   = 1;
      held       = 0;
      exp_resp.delete();
    end else begin
      check_count++;
      if (cfg_ready !== exp_ready) begin
        flag($sformatf("cfg_ready %b expected %b", cfg_ready, exp_ready));
      end
      exp_ready = 1'b1;
      if (exp_live) begin
        check_count++;
        if (input_k !== exp_k || input_beta !== exp_beta || input_ba !== exp_ba) begin
          flag($sformatf("k/beta/ba %h/%b/%b expected %h/%b/%b", input_k, input_beta,
                         input_ba, exp_k, exp_beta, exp_ba));
        end
      end
      check_count++;
      if (query_ready !== (!resp_valid || resp_ready)) begin
        flag($sformatf("query_ready %b with resp_valid %b resp_ready %b", query_ready,
                       resp_valid, resp_ready));
      end
      // Held response must not move
      if (held && (resp_valid !== 1'b1 || display_segment !== held_bit)) begin
        flag("response changed while resp_ready was low");
      end
      if (resp_valid && resp_ready) begin
        check_count++;
        if (exp_resp.size() == 0) begin
          flag("response with no query outstanding");
        end else if (display_segment !== exp_resp[0]) begin
          flag($sformatf("display_segment %b expected %b", display_segment, exp_resp[0]));
          void'(exp_resp.pop_front());
        end else begin
          void'(exp_resp.pop_front());
        end
      end
      held     = resp_valid && !resp_ready;
      held_bit = display_segment;

      // Next registered outputs from this cycle's inputs
      word     = active_column(cpu_kind, strobe_s, strobe_r);
      exp_k    = {control_value(word[31:24], buttons), control_value(word[23:16], buttons),
                  control_value(word[15:8], buttons), control_value(word[7:0], buttons)};
      exp_beta = control_value(beta_model, buttons);
      exp_ba   = control_value(ba_model, buttons);
      exp_live = 1;

      if (cfg_valid && cfg_ready) begin
        if (cfg.index < 8) col_model[cfg.index] = cfg.data;
        else if (cfg.index == 8) beta_model = cfg.data[7:0];
        else if (cfg.index == 9) ba_model = cfg.data[7:0];
      end
    end
  end

endmodule

// ==== tb/tb_gw_lcd_front.sv ====
`timescale 1ns/100ps

module tb_gw_lcd_front
  import gw_pkg::*;
;

  localparam int wait_limit = 100;

  logic       clk_sys_131_072;
  logic       reset;
  logic       cfg_valid;
  logic       cfg_ready;
  cfg_wr_t    cfg;
  buttons_t   buttons;
  cpu_kind_t  cpu_kind;
  logic [7:0] strobe_s;
  logic [3:0] strobe_r;
  logic [3:0] input_k;
  logic       input_beta;
  logic       input_ba;
  logic [1:0] lcd_h_index;
  sm510_seg_t seg_live;
  w_digits_t  w_prime_live;
  w_digits_t  w_main_live;
  logic       tick_1khz;
  logic       vblank;
  logic       query_valid;
  logic       query_ready;
  seg_query_t query;
  logic       resp_valid;
  logic       resp_ready;
  logic       display_segment;

  logic [31:0] rng = 32'd53;

  // Reference copy of what was driven per H
  logic [15:0] a_ref [4];
  logic [15:0] b_ref [4];
  logic        bs_ref [4];

  ////////////////////////////////////////
  // Stimulus tables

  // S0..S7, some codes active low
  logic [31:0] column_words [8] = '{
    32'h85_01_8C_10, 32'h03_82_7F_07, 32'h0E_8D_04_06, 32'h11_96_18_80,
    32'h15_17_93_0C, 32'hFF_05_02_8E, 32'h09_0D_87_81, 32'h10_8F_14_00
  };

  // cpu kind, strobe_s, strobe_r
  logic [12:0] strobe_rows [14] = '{
    {1'b0, 8'h01, 4'h0}, {1'b0, 8'h02, 4'h0}, {1'b0, 8'h04, 4'h0}, {1'b0, 8'h08, 4'h0},
    {1'b0, 8'h10, 4'h0}, {1'b0, 8'h20, 4'h0}, {1'b0, 8'h40, 4'h0}, {1'b0, 8'h80, 4'h0},
    {1'b0, 8'h00, 4'h0}, {1'b0, 8'h60, 4'h0}, {1'b1, 8'hFF, 4'h2}, {1'b1, 8'h00, 4'h4},
    {1'b1, 8'h00, 4'h8}, {1'b1, 8'h01, 4'h1}
  };

  // beta code, BA code
  logic [15:0] beta_ba_rows [4] = '{16'hFF_09, 16'h05_8D, 16'h7F_89, 16'h0E_15};

  // line select, column, row
  logic [9:0] cache_queries [8] = '{
    {4'd0, 4'd3, 2'd0}, {4'd0, 4'd15, 2'd2}, {4'd1, 4'd7, 2'd1}, {4'd1, 4'd0, 2'd3},
    {4'd2, 4'd0, 2'd0}, {4'd2, 4'd0, 2'd3}, {4'd3, 4'd1, 2'd1}, {4'd9, 4'd2, 2'd0}
  };

  gw_lcd_front i_dut (.*);

  gw_checker i_check (
    .clk_sys_131_072(clk_sys_131_072),
    .reset          (reset),
    .cfg_valid      (cfg_valid),
    .cfg_ready      (cfg_ready),
    .cfg            (cfg),
    .buttons        (buttons),
    .cpu_kind       (cpu_kind),
    .strobe_s       (strobe_s),
    .strobe_r       (strobe_r),
    .input_k        (input_k),
    .input_beta     (input_beta),
    .input_ba       (input_ba),
    .query_ready    (query_ready),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .display_segment(display_segment)
  );

  initial clk_sys_131_072 = 1'b0;
  always #10 clk_sys_131_072 = ~clk_sys_131_072;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic random_buttons();
    rng     = xorshift(rng);
    buttons = buttons_t'(rng[11:0]);
  endtask

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("Regression failed");
    $finish;
  endtask

  task automatic write_cfg(input logic [3:0] index, input logic [31:0] data);
    int n;
    n         = 0;
    cfg       = '{index: index, data: data};
    cfg_valid = 1'b1;
    while (!cfg_ready) begin
      @(negedge clk_sys_131_072);
      if (++n > wait_limit) abort_run("cfg_ready");
    end
    @(negedge clk_sys_131_072);
    cfg_valid = 1'b0;
  endtask

  task automatic send_query(input logic [9:0] fields, input bit has, input bit expected);
    int n;
    n = 0;
    i_check.expect_bit(expected);
    query       = '{line_select: fields[9:6], column: fields[5:2], row: fields[1:0],
                    has_segment: has};
    query_valid = 1'b1;
    while (!query_ready) begin
      @(negedge clk_sys_131_072);
      if (++n > wait_limit) abort_run("query_ready");
    end
    @(negedge clk_sys_131_072);
    query_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (i_check.pending() != 0) begin
      @(negedge clk_sys_131_072);
      if (++n > wait_limit) abort_run("outstanding responses");
    end
    @(negedge clk_sys_131_072);
  endtask

  function automatic bit cache_bit(input logic [9:0] f);
    case (f[9:6])
      4'd0:    return a_ref[f[1:0]][f[5:2]];
      4'd1:    return b_ref[f[1:0]][f[5:2]];
      4'd2:    return bs_ref[f[1:0]];
      default: return 1'b0;
    endcase
  endfunction

  task automatic pulse_tick();
    tick_1khz = 1'b1;
    @(negedge clk_sys_131_072);
    tick_1khz = 1'b0;
    @(negedge clk_sys_131_072);
  endtask

  initial begin
    int  cnt;
    bit  shown;
    reset = 1'b1;
    cfg_valid = 1'b0;
    cfg = '0;
    buttons = '0;
    cpu_kind = sm510;
    strobe_s = '0;
    strobe_r = '0;
    lcd_h_index = '0;
    seg_live = '0;
    w_prime_live = '0;
    w_main_live = '0;
    tick_1khz = 1'b0;
    vblank = 1'b0;
    query_valid = 1'b0;
    query = '0;
    resp_ready = 1'b1;
    repeat (3) @(posedge clk_sys_131_072);
    @(negedge clk_sys_131_072);
    reset = 1'b0;

    ////////////////////////////////////////
    // Key columns, both CPU kinds
    for (int i = 0; i < 8; i++) write_cfg(i[3:0], column_words[i]);
    for (int i = 0; i < 14; i++) begin
      cpu_kind = cpu_kind_t'(strobe_rows[i][12]);
      strobe_s = strobe_rows[i][11:4];
      strobe_r = strobe_rows[i][3:0];
      repeat (3) begin
        random_buttons();
        @(negedge clk_sys_131_072);
      end
    end
    i_check.report("columns");

    for (int i = 0; i < 4; i++) begin
      write_cfg(cfg_idx_beta, {24'h0, beta_ba_rows[i][15:8]});
      write_cfg(cfg_idx_ba, {24'h0, beta_ba_rows[i][7:0]});
      repeat (4) begin
        random_buttons();
        @(negedge clk_sys_131_072);
      end
    end
    i_check.report("beta_ba");

    ////////////////////////////////////////
    // SM510 segment cache
    cpu_kind = sm510;
    for (int h = 0; h < 4; h++) begin
      rng       = xorshift(rng);
      a_ref[h]  = rng[15:0];
      b_ref[h]  = rng[31:16];
      bs_ref[h] = rng[7] ^ rng[20];
      lcd_h_index = h[1:0];
      seg_live    = '{a: a_ref[h], b: b_ref[h], bs: bs_ref[h]};
      @(negedge clk_sys_131_072);
    end
    // Nothing cached before vblank
    for (int i = 0; i < 8; i++) send_query(cache_queries[i], 1'b1, 1'b0);
    vblank = 1'b1;
    @(negedge clk_sys_131_072);
    vblank = 1'b0;
    for (int i = 0; i < 8; i++) begin
      send_query(cache_queries[i], 1'b1, cache_bit(cache_queries[i]));
    end
    drain();
    i_check.report("cache");

    ////////////////////////////////////////
    // SM5a decay on digit 2 bit 1
    cpu_kind       = sm5a;
    lcd_h_index    = 2'd0;
    w_main_live[2] = 4'b0010;
    @(negedge clk_sys_131_072);
    cnt = 0;
    for (int t = 1; t <= 49; t++) begin
      if (t == 33) begin
        w_main_live[2] = 4'b0000;
        @(negedge clk_sys_131_072);
      end
      pulse_tick();
      shown = cnt > default_decay_show;
      if (w_main_live[2][1]) cnt = (cnt < default_decay_max) ? cnt + 1 : cnt;
      else cnt = (cnt > 0) ? cnt - 1 : 0;
      send_query({4'd2, 4'd1, 2'd0}, 1'b1, shown);
    end
    drain();
    i_check.report("decay");

    ////////////////////////////////////////
    // Back-pressure on cached SM510 data
    cpu_kind   = sm510;
    resp_ready = 1'b0;
    send_query(cache_queries[0], 1'b1, cache_bit(cache_queries[0]));
    i_check.expect_bit(cache_bit(cache_queries[2]));
    query       = '{line_select: 4'd1, column: 4'd7, row: 2'd1, has_segment: 1'b1};
    query_valid = 1'b1;
    repeat (4) @(negedge clk_sys_131_072);
    resp_ready = 1'b1;
    @(negedge clk_sys_131_072);
    query_valid = 1'b0;
    send_query(cache_queries[0], 1'b0, 1'b0);
    drain();
    i_check.report("backpressure");

    i_check.summary();
    if (i_check.error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/gw_pkg.sv
logic/gw_input_decode.sv
logic/gw_segment_capture.sv
logic/gw_segment_lookup.sv
logic/gw_lcd_front.sv
tb/gw_checker.sv
tb/tb_gw_lcd_front.sv
